// ==== ifetch_cfg.svh ====
// **********************************************************
// Sizes of the fetch stage. Thread, way and set counts must
// be powers of two, with at least two ways
// **********************************************************
`ifndef IFETCH_CFG_SVH
`define IFETCH_CFG_SVH

// Hardware threads sharing the fetch stage
`define IFETCH_THREAD_NUMB 4

// Instruction cache associativity
`define IFETCH_ICACHE_WAY 4

// Sets per way
`define IFETCH_ICACHE_SET 32

// One line holds four instructions
`define IFETCH_ICACHE_LINE_BITS 128

// Byte address width
`define IFETCH_ADDRESS_BITS 32

// Width of one instruction word
`define IFETCH_INSTRUCTION_BITS 32

`endif

// ==== ifetch_pkg.sv ====
// **********************************************************
// Types shared by the fetch stage. Field widths follow from
// the macros in the config header
// **********************************************************
`include "ifetch_cfg.svh"

package ifetch_pkg;

	localparam int THREAD_NUMB = `IFETCH_THREAD_NUMB;
	localparam int ICACHE_WAY = `IFETCH_ICACHE_WAY;
	localparam int ICACHE_SET = `IFETCH_ICACHE_SET;
	localparam int LINE_BITS = `IFETCH_ICACHE_LINE_BITS;
	localparam int ADDRESS_BITS = `IFETCH_ADDRESS_BITS;
	localparam int INSTRUCTION_BITS = `IFETCH_INSTRUCTION_BITS;

	// Derived sizes of the line, its words and the address fields
	localparam int LINE_WORDS = LINE_BITS / INSTRUCTION_BITS;
	localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);
	localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);
	localparam int INDEX_BITS = $clog2(ICACHE_SET);
	localparam int TAG_BITS = ADDRESS_BITS - INDEX_BITS - OFFSET_BITS;

	typedef logic [ADDRESS_BITS-1:0] address_t;
	typedef logic [INSTRUCTION_BITS-1:0] instruction_t;
	typedef logic [$clog2(THREAD_NUMB)-1:0] thread_id_t;
	typedef logic [THREAD_NUMB-1:0] thread_mask_t;
	typedef logic [$clog2(ICACHE_WAY)-1:0] way_id_t;
	typedef logic [ICACHE_WAY-1:0] way_mask_t;
	typedef logic [TAG_BITS-1:0] icache_tag_t;
	typedef logic [INDEX_BITS-1:0] icache_index_t;
	typedef logic [LINE_BITS-1:0] icache_lane_t;

	// Same width as address_t so a cast splits a PC into its cache fields
	typedef struct packed {
		icache_tag_t tag;
		icache_index_t index;
		logic [OFFSET_BITS-1:0] offset;
	} icache_address_t;

	typedef struct packed {
		logic valid;
		thread_id_t thread_id;
		address_t pc;
	} boot_req_t;

	typedef struct packed {
		logic valid;
		address_t address;
		icache_lane_t lane;
	} refill_req_t;

	typedef struct packed {
		logic valid;
		thread_mask_t thread_mask;
		address_t address;
	} miss_report_t;

	typedef struct packed {
		thread_id_t thread_id;
		address_t pc;
		instruction_t instruction;
	} fetch_out_t;

endpackage

// ==== thread_pc_sched.sv ====
// **********************************************************
// Round-robin thread pick and per-thread PCs. The thread count
// must be a power of two so the search index wraps by itself
// **********************************************************
`timescale 1ns/1ps

module thread_pc_sched (
	input  logic                     clk,
	input  logic                     reset,
	input  ifetch_pkg::boot_req_t    boot,
	input  ifetch_pkg::thread_mask_t thread_en,
	input  logic                     miss_pulse,
	input  ifetch_pkg::thread_id_t   miss_thread,
	output logic                     sel_valid,
	output ifetch_pkg::thread_id_t   sel_id,
	output ifetch_pkg::thread_mask_t sel_mask,
	output ifetch_pkg::address_t     sel_pc
);

	// Thread granted last, the search starts just after it
	ifetch_pkg::thread_id_t last_id;
	ifetch_pkg::thread_id_t cand_id;
	ifetch_pkg::thread_id_t grant_id;
	logic grant_found;

	// One PC per hardware thread
	ifetch_pkg::address_t pc_q [ifetch_pkg::THREAD_NUMB];

	// Walk the threads from last_id+1 around to last_id and take the first enabled one
	always_comb begin
		grant_found = 1'b0;
		grant_id = last_id;
		cand_id = last_id;
		for (int i = 1; i <= ifetch_pkg::THREAD_NUMB; i++) begin
			cand_id = last_id + ifetch_pkg::thread_id_t'(i);
			if (!grant_found && thread_en[cand_id]) begin
				grant_found = 1'b1;
				grant_id = cand_id;
			end
		end
	end

	// After reset the pointer sits on the last thread so thread 0 goes first
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			last_id <= '1;
		end else if (grant_found) begin
			last_id <= grant_id;
		end
	end

	assign sel_id = grant_id;
	assign sel_mask = grant_found ? ifetch_pkg::thread_mask_t'(1) << grant_id : '0;
	assign sel_pc = pc_q[grant_id];

	// A thread whose previous lookup misses right now must not read the cache,
	// its PC is being stepped back in this same cycle
	assign sel_valid = grant_found && !(miss_pulse && miss_thread == grant_id);

	// Boot beats a miss restore, which beats the increment on a grant
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int t = 0; t < ifetch_pkg::THREAD_NUMB; t++) begin
				pc_q[t] <= '0;
			end
		end else begin
			for (int t = 0; t < ifetch_pkg::THREAD_NUMB; t++) begin
				if (boot.valid && boot.thread_id == ifetch_pkg::thread_id_t'(t)) begin
					pc_q[t] <= boot.pc;
				end else if (miss_pulse && miss_thread == ifetch_pkg::thread_id_t'(t)) begin
					// Undo the increment made when the missing lookup was issued
					pc_q[t] <= pc_q[t] - ifetch_pkg::address_t'(4);
				end else if (sel_mask[t]) begin
					pc_q[t] <= pc_q[t] + ifetch_pkg::address_t'(4);
				end
			end
		end
	end

endmodule

// ==== icache_ram.sv ====
// **********************************************************
// One-read one-write synchronous RAM with no reset. A read of
// the index being written returns the new entry
// **********************************************************
`timescale 1ns/1ps

module icache_ram #(
	parameter int SIZE = ifetch_pkg::ICACHE_SET,
	parameter type entry_t = ifetch_pkg::icache_tag_t
) (
	input  logic                      clk,
	input  logic                      read_enable,
	input  ifetch_pkg::icache_index_t read_index,
	output entry_t                    read_data,
	input  logic                      write_enable,
	input  ifetch_pkg::icache_index_t write_index,
	input  entry_t                    write_data
);

	entry_t mem [SIZE];

	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[write_index] <= write_data;
		end
		// Read output holds its last value while read_enable is low
		if (read_enable) begin
			if (write_enable && write_index == read_index) begin
				read_data <= write_data;
			end else begin
				read_data <= mem[read_index];
			end
		end
	end

endmodule

// ==== icache_plru.sv ====
// **********************************************************
// Pseudo-LRU victim choice. Needs at least two ways; the low
// victim bits come from one counter shared by all sets
// **********************************************************
`timescale 1ns/1ps

module icache_plru (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      hit_en,
	input  ifetch_pkg::icache_index_t hit_index,
	input  ifetch_pkg::way_mask_t     hit_way,
	input  logic                      fill_en,
	input  ifetch_pkg::icache_index_t fill_index,
	output ifetch_pkg::way_id_t       victim
);

	localparam int HALF_WAYS = ifetch_pkg::ICACHE_WAY / 2;
	localparam int CNT_BITS = $bits(ifetch_pkg::way_id_t) - 1;

	// One bit per set naming the half of the ways to replace next
	logic [ifetch_pkg::ICACHE_SET-1:0] half_bits;
	logic [CNT_BITS-1:0] counter;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			half_bits <= '0;
			counter <= '0;
		end else if (hit_en) begin
			// A hit in the lower half points the next victim at the upper half
			half_bits[hit_index] <= |hit_way[HALF_WAYS-1:0];
			counter <= counter + 1'b1;
		end else if (fill_en) begin
			// The half just filled is now recent, so switch to the other one
			half_bits[fill_index] <= ~half_bits[fill_index];
			counter <= counter + 1'b1;
		end
	end

	// Upper bit picks the half, the counter picks the way inside it
	assign victim = {half_bits[fill_index], counter};

endmodule

// ==== icache_lookup.sv ====
// **********************************************************
// Tag and data ways with line valid bits. The read is issued
// in stage 0 and the compare happens one cycle later
// **********************************************************
`timescale 1ns/1ps

module icache_lookup (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   read_en,
	input  ifetch_pkg::icache_index_t              read_index,
	input  ifetch_pkg::icache_tag_t                cmp_tag,
	input  logic [ifetch_pkg::WORD_SEL_BITS-1:0]   word_sel,
	input  ifetch_pkg::refill_req_t                refill,
	input  ifetch_pkg::way_id_t                    victim,
	output logic                                   hit,
	output ifetch_pkg::way_mask_t                  hit_way,
	output ifetch_pkg::instruction_t               word
);

	// Refill address seen as tag, index and offset
	ifetch_pkg::icache_address_t fill_addr;

	// Per-way outputs of the tag and data RAMs
	ifetch_pkg::icache_tag_t tag_rd [ifetch_pkg::ICACHE_WAY];
	ifetch_pkg::icache_lane_t data_rd [ifetch_pkg::ICACHE_WAY];

	// Valid bit of each way for the set read in the previous cycle
	ifetch_pkg::way_mask_t valid_q;

	ifetch_pkg::icache_lane_t hit_line;

	assign fill_addr = ifetch_pkg::icache_address_t'(refill.address);

	for (genvar w = 0; w < ifetch_pkg::ICACHE_WAY; w++) begin : gen_way
		// Line valid bits live in flops so that reset can clear them
		logic [ifetch_pkg::ICACHE_SET-1:0] line_valid;
		logic way_write;

		// Only the way chosen by the pLRU takes the refill
		assign way_write = refill.valid && victim == ifetch_pkg::way_id_t'(w);

		icache_ram #(
			.SIZE(ifetch_pkg::ICACHE_SET),
			.entry_t(ifetch_pkg::icache_tag_t)
		) u_tag_ram (
			.clk(clk),
			.read_enable(read_en),
			.read_index(read_index),
			.read_data(tag_rd[w]),
			.write_enable(way_write),
			.write_index(fill_addr.index),
			.write_data(fill_addr.tag)
		);

		icache_ram #(
			.SIZE(ifetch_pkg::ICACHE_SET),
			.entry_t(ifetch_pkg::icache_lane_t)
		) u_data_ram (
			.clk(clk),
			.read_enable(read_en),
			.read_index(read_index),
			.read_data(data_rd[w]),
			.write_enable(way_write),
			.write_index(fill_addr.index),
			.write_data(refill.lane)
		);

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				line_valid <= '0;
				valid_q[w] <= 1'b0;
			end else begin
				if (way_write) begin
					line_valid[fill_addr.index] <= 1'b1;
				end
				// An idle cycle leaves no valid way behind, so no false hit
				valid_q[w] <= line_valid[read_index] & read_en;
			end
		end

		// A way hits when it held a valid line and the stored tag matches
		assign hit_way[w] = valid_q[w] && tag_rd[w] == cmp_tag;
	end

	assign hit = |hit_way;

	// At most one way hits, so an AND-OR mux picks its line
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < ifetch_pkg::ICACHE_WAY; w++) begin
			if (hit_way[w]) begin
				hit_line = hit_line | data_rd[w];
			end
		end
	end

	// Word 0 sits in the low bits of the line
	assign word = hit_line[word_sel * ifetch_pkg::INSTRUCTION_BITS +: ifetch_pkg::INSTRUCTION_BITS];

endmodule

// ==== instruction_fetch.sv ====
// **********************************************************
// Fetch stage top. No back-pressure: every fetch and miss
// report must be taken in the cycle it is valid
// **********************************************************
`timescale 1ns/1ps

module instruction_fetch (
	input  logic                     clk,
	input  logic                     reset,
	input  ifetch_pkg::boot_req_t    boot,
	input  ifetch_pkg::thread_mask_t thread_en,
	input  ifetch_pkg::refill_req_t  refill,
	output logic                     fetch_valid,
	output ifetch_pkg::fetch_out_t   fetch,
	output ifetch_pkg::miss_report_t miss
);

	// Stage 0 selection from the scheduler
	logic sel_valid;
	ifetch_pkg::thread_id_t sel_id;
	ifetch_pkg::thread_mask_t sel_mask;
	ifetch_pkg::address_t sel_pc;

	// Stage 1 registers, aligned with the cache read data
	logic s1_valid;
	ifetch_pkg::thread_id_t s1_id;
	ifetch_pkg::thread_mask_t s1_mask;
	ifetch_pkg::address_t s1_pc;

	ifetch_pkg::icache_address_t s0_addr;
	ifetch_pkg::icache_address_t s1_addr;
	ifetch_pkg::icache_address_t fill_addr;

	logic hit;
	logic s1_miss;
	ifetch_pkg::way_mask_t hit_way;
	ifetch_pkg::way_id_t victim;
	ifetch_pkg::instruction_t word;

	assign s0_addr = ifetch_pkg::icache_address_t'(sel_pc);
	assign s1_addr = ifetch_pkg::icache_address_t'(s1_pc);
	assign fill_addr = ifetch_pkg::icache_address_t'(refill.address);

	thread_pc_sched u_sched (
		.clk(clk),
		.reset(reset),
		.boot(boot),
		.thread_en(thread_en),
		.miss_pulse(s1_miss),
		.miss_thread(s1_id),
		.sel_valid(sel_valid),
		.sel_id(sel_id),
		.sel_mask(sel_mask),
		.sel_pc(sel_pc)
	);

	icache_lookup u_lookup (
		.clk(clk),
		.reset(reset),
		.read_en(sel_valid),
		.read_index(s0_addr.index),
		.cmp_tag(s1_addr.tag),
		.word_sel(s1_addr.offset[ifetch_pkg::OFFSET_BITS-1 -: ifetch_pkg::WORD_SEL_BITS]),
		.refill(refill),
		.victim(victim),
		.hit(hit),
		.hit_way(hit_way),
		.word(word)
	);

	// Only a valid stage-1 hit refreshes the replacement state
	icache_plru u_plru (
		.clk(clk),
		.reset(reset),
		.hit_en(s1_valid & hit),
		.hit_index(s1_addr.index),
		.hit_way(hit_way),
		.fill_en(refill.valid),
		.fill_index(fill_addr.index),
		.victim(victim)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s1_id <= '0;
		end else begin
			s1_valid <= sel_valid;
			s1_id <= sel_id;
		end
	end

	always_ff @(posedge clk) begin
		s1_mask <= sel_mask;
		s1_pc <= sel_pc;
	end

	// The miss report leaves in stage 1 without a register
	assign s1_miss = s1_valid & ~hit;
	assign miss = '{valid: s1_miss, thread_mask: s1_mask, address: s1_pc};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= s1_valid & hit;
		end
	end

	always_ff @(posedge clk) begin
		fetch <= '{thread_id: s1_id, pc: s1_pc, instruction: word};
	end

endmodule

// ==== tb_instruction_fetch.sv ====
// ************************************************************
// Directed testbench for the fetch stage. Refills are only sent
// while every thread is disabled and the pipeline has drained
// ************************************************************
`timescale 1ns/1ps

module tb_instruction_fetch;

	// The tests need a few hundred cycles, this leaves a wide margin
	localparam int CYCLE_LIMIT = 4000;

	logic clk;
	logic reset;
	ifetch_pkg::boot_req_t boot;
	ifetch_pkg::thread_mask_t thread_en;
	ifetch_pkg::refill_req_t refill;
	logic fetch_valid;
	ifetch_pkg::fetch_out_t fetch;
	ifetch_pkg::miss_report_t miss;

	// Responses collected by the monitor and consumed by the tests
	ifetch_pkg::fetch_out_t fetch_q [$];
	ifetch_pkg::miss_report_t miss_q [$];

	// Line contents sent by refills, keyed by line address
	ifetch_pkg::icache_lane_t line_model [ifetch_pkg::address_t];

	// Mirror of the replacement state and of the tag each way holds
	logic [ifetch_pkg::ICACHE_SET-1:0] half_bits;
	logic [$bits(ifetch_pkg::way_id_t)-2:0] plru_cnt;
	ifetch_pkg::icache_tag_t way_tag [ifetch_pkg::ICACHE_SET][ifetch_pkg::ICACHE_WAY];
	ifetch_pkg::way_mask_t way_valid [ifetch_pkg::ICACHE_SET];

	logic [31:0] rng_state;
	int cycle_count;

	instruction_fetch UUT (
		.clk(clk),
		.reset(reset),
		.boot(boot),
		.thread_en(thread_en),
		.refill(refill),
		.fetch_valid(fetch_valid),
		.fetch(fetch),
		.miss(miss)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_fetch(input ifetch_pkg::fetch_out_t exp,
			input ifetch_pkg::fetch_out_t act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: fetch expected %h actual %h", $time, exp, act));
		end
	endtask

	task automatic check_miss(input ifetch_pkg::miss_report_t exp,
			input ifetch_pkg::miss_report_t act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: miss expected %h actual %h", $time, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s expected %b actual %b",
				$time, name, exp, act));
		end
	endtask

	task automatic expect_count(input string what, input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("wrong number of %s: expected %0d, got %0d", what, exp, act));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic ifetch_pkg::address_t line_of(input ifetch_pkg::address_t a);
		return a & ~ifetch_pkg::address_t'(ifetch_pkg::LINE_BITS / 8 - 1);
	endfunction

	// Expected instruction is the model word picked by PC bits 3:2
	function automatic ifetch_pkg::instruction_t model_word(input ifetch_pkg::address_t pc);
		ifetch_pkg::icache_lane_t line;
		line = line_model[line_of(pc)];
		return ifetch_pkg::instruction_t'(line >> (pc[3:2] * ifetch_pkg::INSTRUCTION_BITS));
	endfunction

	// Way that holds the line of a in the mirror, -1 when none does
	function automatic int mirror_way(input ifetch_pkg::address_t a);
		ifetch_pkg::icache_address_t f;
		f = ifetch_pkg::icache_address_t'(a);
		for (int w = 0; w < ifetch_pkg::ICACHE_WAY; w++) begin
			if (way_valid[f.index][w] && way_tag[f.index][w] == f.tag) begin
				return w;
			end
		end
		return -1;
	endfunction

	// Victim is the set's half bit on top of the shared counter, then the half flips
	task automatic mirror_fill(input ifetch_pkg::address_t a);
		ifetch_pkg::icache_address_t f;
		ifetch_pkg::way_id_t v;
		f = ifetch_pkg::icache_address_t'(a);
		v = {half_bits[f.index], plru_cnt};
		way_tag[f.index][v] = f.tag;
		way_valid[f.index][v] = 1'b1;
		half_bits[f.index] = ~half_bits[f.index];
		plru_cnt = plru_cnt + 1'b1;
	endtask

	// A hit in the lower half points the next victim at the upper half
	task automatic mirror_hit(input ifetch_pkg::address_t a);
		ifetch_pkg::icache_address_t f;
		int w;
		f = ifetch_pkg::icache_address_t'(a);
		w = mirror_way(a);
		if (w < 0) begin
			abort_run($sformatf("fetch of pc %h came from a line the cache should not hold", a));
		end else begin
			half_bits[f.index] = (w < ifetch_pkg::ICACHE_WAY / 2);
			plru_cnt = plru_cnt + 1'b1;
		end
	endtask

	// Outputs are read at the falling edge, well after they settle
	always @(negedge clk) begin
		if (!reset) begin
			if (fetch_valid) begin
				fetch_q.push_back(fetch);
				mirror_hit(fetch.pc);
			end
			if (miss.valid) begin
				miss_q.push_back(miss);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			abort_run($sformatf("timeout: run still going after %0d cycles", CYCLE_LIMIT));
		end
	end

	task automatic send_refill(input ifetch_pkg::address_t a);
		ifetch_pkg::icache_lane_t lane;
		for (int i = 0; i < ifetch_pkg::LINE_WORDS; i++) begin
			rng_state = xorshift32(rng_state);
			lane[i*32 +: 32] = rng_state;
		end
		line_model[line_of(a)] = lane;
		@(posedge clk);
		mirror_fill(a);
		refill <= ifetch_pkg::refill_req_t'{valid: 1'b1, address: a, lane: lane};
		@(posedge clk);
		refill <= '0;
	endtask

	task automatic boot_thread(input int t, input ifetch_pkg::address_t pc);
		@(posedge clk);
		boot <= ifetch_pkg::boot_req_t'{valid: 1'b1,
			thread_id: ifetch_pkg::thread_id_t'(t), pc: pc};
		@(posedge clk);
		boot <= '0;
	endtask

	task automatic enable_threads(input ifetch_pkg::thread_mask_t m);
		@(posedge clk);
		thread_en <= m;
	endtask

	// Two cycles empty the pipeline, the third is margin
	task automatic stop_and_drain;
		@(posedge clk);
		thread_en <= '0;
		repeat (3) @(posedge clk);
	endtask

	task automatic clear_queues;
		fetch_q.delete();
		miss_q.delete();
	endtask

	task automatic wait_responses(input int fetches, input int misses, input int max_cycles);
		int n;
		n = 0;
		while (fetch_q.size() < fetches || miss_q.size() < misses) begin
			if (n == max_cycles) begin
				abort_run($sformatf("no response after %0d cycles: %0d fetches and %0d misses seen",
					max_cycles, fetch_q.size(), miss_q.size()));
			end else begin
				n++;
				@(posedge clk);
			end
		end
	endtask

	task automatic test_reset;
		repeat (10) begin
			@(negedge clk);
			check_bit("fetch_valid", 1'b0, fetch_valid);
			check_bit("miss.valid", 1'b0, miss.valid);
		end
	endtask

	// The PC steps back after every miss, so the same address keeps missing
	task automatic test_cold_miss(input ifetch_pkg::address_t a);
		boot_thread(0, a);
		enable_threads(4'b0001);
		wait_responses(0, 4, 40);
		stop_and_drain();
		expect_count("fetches from an empty cache", 0, fetch_q.size());
		foreach (miss_q[i]) begin
			check_miss(ifetch_pkg::miss_report_t'{valid: 1'b1, thread_mask: 4'b0001, address: a},
				miss_q[i]);
		end
		clear_queues();
	endtask

	// Thread 0 still sits at a, it walks the line and misses on the next one
	task automatic test_fill_hits(input ifetch_pkg::address_t a);
		ifetch_pkg::address_t pc;
		send_refill(a);
		enable_threads(4'b0001);
		wait_responses(ifetch_pkg::LINE_WORDS, 1, 60);
		stop_and_drain();
		expect_count("fetches from one line", ifetch_pkg::LINE_WORDS, fetch_q.size());
		foreach (fetch_q[i]) begin
			pc = a + ifetch_pkg::address_t'(4 * i);
			check_fetch(ifetch_pkg::fetch_out_t'{thread_id: '0, pc: pc,
				instruction: model_word(pc)}, fetch_q[i]);
		end
		foreach (miss_q[i]) begin
			check_miss(ifetch_pkg::miss_report_t'{valid: 1'b1, thread_mask: 4'b0001,
				address: line_of(a) + ifetch_pkg::LINE_BITS / 8}, miss_q[i]);
		end
		clear_queues();
	endtask

	task automatic test_round_robin(input ifetch_pkg::address_t base);
		ifetch_pkg::address_t start [ifetch_pkg::THREAD_NUMB];
		ifetch_pkg::address_t next_pc [ifetch_pkg::THREAD_NUMB];
		ifetch_pkg::thread_id_t id;
		int t;
		// Lines sit in every other set so the line after each one stays empty
		for (int i = 0; i < ifetch_pkg::THREAD_NUMB; i++) begin
			start[i] = base + ifetch_pkg::address_t'(32 * i);
			next_pc[i] = start[i];
			send_refill(start[i]);
			boot_thread(i, start[i]);
		end
		enable_threads('1);
		wait_responses(16, 4, 200);
		stop_and_drain();
		expect_count("fetches in round robin", 16, fetch_q.size());
		// Only thread 0 was granted so far, so the search starts at thread 1
		id = ifetch_pkg::thread_id_t'(1);
		foreach (fetch_q[i]) begin
			check_fetch(ifetch_pkg::fetch_out_t'{thread_id: id, pc: next_pc[id],
				instruction: model_word(next_pc[id])}, fetch_q[i]);
			next_pc[id] = next_pc[id] + 4;
			id = id + 1'b1;
		end
		foreach (miss_q[i]) begin
			t = 0;
			for (int k = 0; k < ifetch_pkg::THREAD_NUMB; k++) begin
				if (miss_q[i].thread_mask[k]) begin
					t = k;
				end
			end
			check_miss(ifetch_pkg::miss_report_t'{valid: 1'b1,
				thread_mask: ifetch_pkg::thread_mask_t'(1) << t, address: start[t] + 16}, miss_q[i]);
		end
		clear_queues();
	endtask

	// Five lines share set 20, so at least one of them gets evicted
	task automatic test_replacement;
		ifetch_pkg::address_t probe [5];
		ifetch_pkg::icache_address_t f;
		logic held;
		for (int i = 0; i < 5; i++) begin
			f.tag = ifetch_pkg::icache_tag_t'(200 + i);
			f.index = ifetch_pkg::icache_index_t'(20);
			f.offset = '0;
			probe[i] = ifetch_pkg::address_t'(f);
			send_refill(probe[i]);
		end
		for (int i = 0; i < 5; i++) begin
			held = (mirror_way(probe[i]) >= 0);
			boot_thread(0, probe[i]);
			// One enabled cycle issues exactly one lookup
			enable_threads(4'b0001);
			@(posedge clk);
			thread_en <= '0;
			wait_responses(held ? 1 : 0, held ? 0 : 1, 10);
			repeat (3) @(posedge clk);
			expect_count("responses to one probe", 1, fetch_q.size() + miss_q.size());
			if (held) begin
				check_fetch(ifetch_pkg::fetch_out_t'{thread_id: '0, pc: probe[i],
					instruction: model_word(probe[i])}, fetch_q[0]);
			end else begin
				check_miss(ifetch_pkg::miss_report_t'{valid: 1'b1, thread_mask: 4'b0001,
					address: probe[i]}, miss_q[0]);
			end
			clear_queues();
		end
	endtask

	initial begin
		reset = 1'b1;
		boot = '0;
		thread_en = '0;
		refill = '0;
		rng_state = 32'h7c0d;
		cycle_count = 0;
		half_bits = '0;
		plru_cnt = '0;
		for (int s = 0; s < ifetch_pkg::ICACHE_SET; s++) begin
			way_valid[s] = '0;
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		test_reset();
		test_cold_miss(32'h0000_1000);
		test_fill_hits(32'h0000_1000);
		test_round_robin(32'h0000_3040);
		test_replacement();
		$display("test passed");
		$finish;
	end

endmodule

// ==== instruction_fetch.f ====
+incdir+.
ifetch_pkg.sv
thread_pc_sched.sv
icache_ram.sv
icache_plru.sv
icache_lookup.sv
instruction_fetch.sv
tb_instruction_fetch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch stage testbench with Verilator and runs it.
# A failing check ends the run with $fatal, which gives a non-zero exit status.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_instruction_fetch \
	-f instruction_fetch.f
./obj_dir/Vtb_instruction_fetch
